//--- build.f
source/shell_pkg.sv
source/host_req_port.sv
source/access_decoder.sv
source/syscfg_reg_blk.sv
source/dna_reader.sv
source/response_collector.sv
source/shell_top.sv
tests/tb_shell_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the shell testbench with Verilator, result is taken from sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_shell_top -f build.f -o sim_tb_shell_top \
    && ./obj_dir/sim_tb_shell_top > sim.log 2>&1 \
    && ! grep -qF "*** TEST FAILED ***" sim.log \
    && grep -qF "*** TEST PASSED ***" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- source/access_decoder.sv
`timescale 1ns/10ps

module access_decoder (
    input  logic                              clk,
    input  logic                              i_rst,
    input  logic                              i_start,
    input  shell_pkg::reg_addr_u              i_addr,
    input  logic                              i_wr,
    output logic [shell_pkg::TGT_W-1:0]       o_sel,
    output logic [shell_pkg::IDX_W-1:0]       o_index,
    output logic                              o_go,
    output logic                              o_app_go
);
    logic [shell_pkg::TGT_W-1:0] sel_nxt;

    // Bus view first, then the platform view
    always_comb begin
        sel_nxt = '0;
        if (i_addr.bus.app) begin
            sel_nxt[shell_pkg::TGT_APP] = 1'b1;
        end else if (i_addr.plat.byte_off != 2'b00) begin
            sel_nxt[shell_pkg::TGT_NONE] = 1'b1;
        end else begin
            case (i_addr.plat.blk)
                shell_pkg::BLK_SYSCFG: sel_nxt[shell_pkg::TGT_SYSCFG] = 1'b1;
                shell_pkg::BLK_DNA:    sel_nxt[shell_pkg::TGT_DNA]    = 1'b1;
                // Sysmon, QSPI and spare blocks
                default:               sel_nxt[shell_pkg::TGT_NONE]   = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_sel    <= '0;
            o_go     <= 1'b0;
            o_app_go <= 1'b0;
        end else begin
            o_go     <= i_start;
            o_app_go <= i_start && i_addr.bus.app;
            if (i_start) begin
                o_sel <= sel_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            o_index <= i_addr.plat.index;
        end
    end

    a_sel_onehot: assert property (@(posedge clk) disable iff (i_rst)
        o_go |-> $onehot(o_sel))
        else $error("target select not one-hot on go");

    a_start_known: assert property (@(posedge clk) disable iff (i_rst)
        i_start |-> !$isunknown({i_wr, i_addr}))
        else $error("unknown request fields on start");

endmodule : access_decoder

//--- source/dna_reader.sv
`timescale 1ns/10ps

module dna_reader (
    input  logic                          clk,
    input  logic                          i_rst,
    input  logic                          i_dna_dout,
    output logic                          o_dna_read,
    output logic                          o_dna_shift,
    output logic [shell_pkg::DNA_W-1:0]   o_dna,
    output logic                          o_dna_valid
);
    logic [$clog2(shell_pkg::DNA_W + 2)-1:0] step;

    // Step 0 loads, steps 1..DNA_W shift, then the value is held
    always_ff @(posedge clk) begin
        if (i_rst) begin
            step        <= '0;
            o_dna_read  <= 1'b0;
            o_dna_shift <= 1'b0;
            o_dna_valid <= 1'b0;
        end else if (!o_dna_valid) begin
            o_dna_read  <= (step == '0);
            o_dna_shift <= (step != '0) && (step <= shell_pkg::DNA_W);
            if (step == shell_pkg::DNA_W + 1) begin
                o_dna_valid <= 1'b1;
            end
            step <= step + 1'b1;
        end
    end

    // MSB first, sampled on every shift cycle
    always_ff @(posedge clk) begin
        if (o_dna_shift) begin
            o_dna <= {o_dna[shell_pkg::DNA_W-2:0], i_dna_dout};
        end
    end

    a_no_shift_when_valid: assert property (@(posedge clk) disable iff (i_rst)
        !(o_dna_shift && o_dna_valid))
        else $error("DNA shift while value marked valid");

endmodule : dna_reader

//--- source/host_req_port.sv
`timescale 1ns/10ps

module host_req_port (
    input  logic                          clk,
    input  logic                          i_rst,
    // Host side
    input  logic                          i_req,
    input  logic                          i_wr,
    input  shell_pkg::reg_addr_u          i_addr,
    input  logic [shell_pkg::DATA_W-1:0]  i_wdata,
    output logic                          o_ack,
    output logic [shell_pkg::DATA_W-1:0]  o_rdata,
    output logic                          o_err,
    // To decoder
    output logic                          o_start,
    output shell_pkg::reg_addr_u          o_addr,
    output logic                          o_wr,
    output logic [shell_pkg::DATA_W-1:0]  o_wdata,
    // From decoder and collector
    input  logic                          i_app_go,
    input  logic                          i_done,
    input  logic [shell_pkg::DATA_W-1:0]  i_rdata,
    input  logic                          i_err,
    // Application core side
    output logic                          o_app_req,
    output logic                          o_app_wr,
    output logic [14:0]                   o_app_addr,
    output logic [shell_pkg::DATA_W-1:0]  o_app_wdata,
    input  logic                          i_app_ack,
    input  logic [shell_pkg::DATA_W-1:0]  i_app_rdata,
    input  logic                          i_app_err,
    // To collector
    output logic                          o_app_done,
    output logic [shell_pkg::DATA_W-1:0]  o_app_rdata,
    output logic                          o_app_err
);
    logic [2:0] state;

    // Application fields come straight from the captured request
    assign o_app_addr  = o_addr.bus.offset;
    assign o_app_wr    = o_wr;
    assign o_app_wdata = o_wdata;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state      <= shell_pkg::HP_IDLE;
            o_start    <= 1'b0;
            o_ack      <= 1'b0;
            o_app_req  <= 1'b0;
            o_app_done <= 1'b0;
        end else begin
            o_start    <= 1'b0;
            o_app_done <= 1'b0;
            case (state)
                shell_pkg::HP_IDLE: begin
                    if (i_req && !o_ack) begin
                        o_start <= 1'b1;
                        state   <= shell_pkg::HP_BUSY;
                    end
                end
                shell_pkg::HP_BUSY: begin
                    if (i_app_go) begin
                        o_app_req <= 1'b1;
                        state     <= shell_pkg::HP_APP_REQ;
                    end else if (i_done) begin
                        o_ack <= 1'b1;
                        state <= shell_pkg::HP_ACK;
                    end
                end
                shell_pkg::HP_APP_REQ: begin
                    if (i_app_ack) begin
                        o_app_req <= 1'b0;
                        state     <= shell_pkg::HP_APP_END;
                    end
                end
                // Core access is over only once its ack has dropped
                shell_pkg::HP_APP_END: begin
                    if (!i_app_ack) begin
                        o_app_done <= 1'b1;
                        state      <= shell_pkg::HP_BUSY;
                    end
                end
                shell_pkg::HP_ACK: begin
                    if (!i_req) begin
                        o_ack <= 1'b0;
                        state <= shell_pkg::HP_IDLE;
                    end
                end
                default: state <= shell_pkg::HP_IDLE;
            endcase
        end
    end

    // ==============================
    // Payload capture
    // ==============================
    always_ff @(posedge clk) begin
        if (state == shell_pkg::HP_IDLE && i_req && !o_ack) begin
            o_addr  <= i_addr;
            o_wr    <= i_wr;
            o_wdata <= i_wdata;
        end
        if (state == shell_pkg::HP_APP_REQ && i_app_ack) begin
            o_app_rdata <= i_app_rdata;
            o_app_err   <= i_app_err;
        end
        if (state == shell_pkg::HP_BUSY && !i_app_go && i_done) begin
            o_rdata <= i_rdata;
            o_err   <= i_err;
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (i_rst)
        $rose(o_ack) |-> i_req)
        else $error("o_ack rose without i_req");

    a_app_stable: assert property (@(posedge clk) disable iff (i_rst)
        o_app_req && $past(o_app_req) |-> $stable({o_app_addr, o_app_wr, o_app_wdata}))
        else $error("application fields changed during o_app_req");

endmodule : host_req_port

//--- source/response_collector.sv
`timescale 1ns/10ps

module response_collector (
    input  logic                          clk,
    input  logic                          i_rst,
    input  logic                          i_go,
    input  logic [shell_pkg::TGT_W-1:0]   i_sel,
    input  logic                          i_reg_done,
    input  logic [shell_pkg::DATA_W-1:0]  i_reg_rdata,
    input  logic                          i_reg_err,
    input  logic                          i_app_done,
    input  logic [shell_pkg::DATA_W-1:0]  i_app_rdata,
    input  logic                          i_app_err,
    output logic                          o_done,
    output logic [shell_pkg::DATA_W-1:0]  o_rdata,
    output logic                          o_err
);
    logic none_pend;
    logic app_fin;

    assign app_fin = i_app_done && i_sel[shell_pkg::TGT_APP];

    // Unmapped accesses take one extra cycle, same as a register target
    always_ff @(posedge clk) begin
        if (i_rst) begin
            none_pend <= 1'b0;
            o_done    <= 1'b0;
        end else begin
            none_pend <= i_go && i_sel[shell_pkg::TGT_NONE];
            o_done    <= none_pend || i_reg_done || app_fin;
        end
    end

    always_ff @(posedge clk) begin
        if (none_pend) begin
            o_rdata <= '0;
            o_err   <= 1'b1;
        end else if (app_fin) begin
            o_rdata <= i_app_rdata;
            o_err   <= i_app_err;
        end else if (i_reg_done) begin
            o_rdata <= i_reg_rdata;
            o_err   <= i_reg_err;
        end
    end

endmodule : response_collector

//--- source/shell_pkg.sv
package shell_pkg;

    // ==============================
    // Bus widths
    // ==============================
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int IDX_W  = 10;

    // One address word, read at bus level or at platform level
    typedef union packed {
        struct packed {
            logic        app;
            logic [14:0] offset;
        } bus;
        struct packed {
            logic             top;
            logic [2:0]       blk;
            logic [IDX_W-1:0] index;
            logic [1:0]       byte_off;
        } plat;
    } reg_addr_u;

    // Mapped platform blocks, everything else is unmapped
    localparam logic [2:0] BLK_SYSCFG = 3'd0;
    localparam logic [2:0] BLK_DNA    = 3'd1;

    // System config register indices
    localparam logic [IDX_W-1:0] REG_BUILD    = 10'd0;
    localparam logic [IDX_W-1:0] REG_STATUS   = 10'd1;
    localparam logic [IDX_W-1:0] REG_SCRATCH  = 10'd2;
    localparam logic [IDX_W-1:0] REG_RST_CTRL = 10'd3;

    localparam int DNA_W = 96;

    // Core reset pulse length and its down-counter
    localparam int CORE_RST_CYCLES = 16;
    localparam int RST_CNT_W = $clog2(CORE_RST_CYCLES);
    localparam logic [RST_CNT_W-1:0] RST_CNT_LOAD = RST_CNT_W'(CORE_RST_CYCLES - 1);

    // One-hot target select bit positions
    localparam int TGT_W      = 4;
    localparam int TGT_SYSCFG = 0;
    localparam int TGT_DNA    = 1;
    localparam int TGT_APP    = 2;
    localparam int TGT_NONE   = 3;

    // Host port FSM states
    localparam logic [2:0] HP_IDLE    = 3'd0;
    localparam logic [2:0] HP_BUSY    = 3'd1;
    localparam logic [2:0] HP_APP_REQ = 3'd2;
    localparam logic [2:0] HP_APP_END = 3'd3;
    localparam logic [2:0] HP_ACK     = 3'd4;

endpackage : shell_pkg

//--- source/shell_top.sv
`timescale 1ns/10ps

module shell_top #(
    parameter bit [31:0] BUILD_TIMESTAMP = 32'h0
) (
    input  logic                          clk,
    input  logic                          i_rst,
    // Host register bus
    input  logic                          i_req,
    input  logic                          i_wr,
    input  shell_pkg::reg_addr_u          i_addr,
    input  logic [shell_pkg::DATA_W-1:0]  i_wdata,
    output logic                          o_ack,
    output logic [shell_pkg::DATA_W-1:0]  o_rdata,
    output logic                          o_err,
    // Application core port
    output logic                          o_app_req,
    output logic                          o_app_wr,
    output logic [14:0]                   o_app_addr,
    output logic [shell_pkg::DATA_W-1:0]  o_app_wdata,
    input  logic                          i_app_ack,
    input  logic [shell_pkg::DATA_W-1:0]  i_app_rdata,
    input  logic                          i_app_err,
    // Device DNA port
    output logic                          o_dna_read,
    output logic                          o_dna_shift,
    input  logic                          i_dna_dout,
    // Core reset
    output logic                          o_core_srst
);
    // ==============================
    // Internal signals
    // ==============================
    logic                          start;
    shell_pkg::reg_addr_u          cap_addr;
    logic                          cap_wr;
    logic [shell_pkg::DATA_W-1:0]  cap_wdata;
    logic [shell_pkg::TGT_W-1:0]   sel;
    logic [shell_pkg::IDX_W-1:0]   index;
    logic                          go;
    logic                          app_go;
    logic                          reg_done;
    logic [shell_pkg::DATA_W-1:0]  reg_rdata;
    logic                          reg_err;
    logic                          app_done;
    logic [shell_pkg::DATA_W-1:0]  app_rdata;
    logic                          app_err;
    logic                          rsp_done;
    logic [shell_pkg::DATA_W-1:0]  rsp_rdata;
    logic                          rsp_err;
    logic [shell_pkg::DNA_W-1:0]   dna;
    logic                          dna_valid;

    host_req_port i_host_req_port (
        .clk, .i_rst, .i_req, .i_wr, .i_addr, .i_wdata, .o_ack, .o_rdata, .o_err,
        .o_start     ( start ),
        .o_addr      ( cap_addr ),
        .o_wr        ( cap_wr ),
        .o_wdata     ( cap_wdata ),
        .i_app_go    ( app_go ),
        .i_done      ( rsp_done ),
        .i_rdata     ( rsp_rdata ),
        .i_err       ( rsp_err ),
        .o_app_req, .o_app_wr, .o_app_addr, .o_app_wdata,
        .i_app_ack, .i_app_rdata, .i_app_err,
        .o_app_done  ( app_done ),
        .o_app_rdata ( app_rdata ),
        .o_app_err   ( app_err )
    );

    access_decoder i_access_decoder (
        .clk, .i_rst,
        .i_start  ( start ),
        .i_addr   ( cap_addr ),
        .i_wr     ( cap_wr ),
        .o_sel    ( sel ),
        .o_index  ( index ),
        .o_go     ( go ),
        .o_app_go ( app_go )
    );

    // ==============================
    // Platform targets
    // ==============================
    syscfg_reg_blk #(
        .BUILD_TIMESTAMP ( BUILD_TIMESTAMP )
    ) i_syscfg_reg_blk (
        .clk, .i_rst,
        .i_go        ( go ),
        .i_sel       ( sel ),
        .i_index     ( index ),
        .i_wr        ( cap_wr ),
        .i_wdata     ( cap_wdata ),
        .i_dna       ( dna ),
        .i_dna_valid ( dna_valid ),
        .o_done      ( reg_done ),
        .o_rdata     ( reg_rdata ),
        .o_err       ( reg_err ),
        .o_core_srst
    );

    dna_reader i_dna_reader (
        .clk, .i_rst, .i_dna_dout, .o_dna_read, .o_dna_shift,
        .o_dna       ( dna ),
        .o_dna_valid ( dna_valid )
    );

    response_collector i_response_collector (
        .clk, .i_rst,
        .i_go        ( go ),
        .i_sel       ( sel ),
        .i_reg_done  ( reg_done ),
        .i_reg_rdata ( reg_rdata ),
        .i_reg_err   ( reg_err ),
        .i_app_done  ( app_done ),
        .i_app_rdata ( app_rdata ),
        .i_app_err   ( app_err ),
        .o_done      ( rsp_done ),
        .o_rdata     ( rsp_rdata ),
        .o_err       ( rsp_err )
    );

endmodule : shell_top

//--- source/syscfg_reg_blk.sv
`timescale 1ns/10ps

module syscfg_reg_blk #(
    parameter bit [31:0] BUILD_TIMESTAMP = 32'h0
) (
    input  logic                              clk,
    input  logic                              i_rst,
    input  logic                              i_go,
    input  logic [shell_pkg::TGT_W-1:0]       i_sel,
    input  logic [shell_pkg::IDX_W-1:0]       i_index,
    input  logic                              i_wr,
    input  logic [shell_pkg::DATA_W-1:0]      i_wdata,
    input  logic [shell_pkg::DNA_W-1:0]       i_dna,
    input  logic                              i_dna_valid,
    output logic                              o_done,
    output logic [shell_pkg::DATA_W-1:0]      o_rdata,
    output logic                              o_err,
    output logic                              o_core_srst
);
    logic [shell_pkg::DATA_W-1:0]    scratch;
    logic [shell_pkg::RST_CNT_W-1:0] rst_cnt;
    logic [shell_pkg::DATA_W-1:0]    rd_val;
    logic                            wr_err;
    logic                            cfg_hit;
    logic                            dna_hit;

    assign cfg_hit = i_go && i_sel[shell_pkg::TGT_SYSCFG];
    assign dna_hit = i_go && i_sel[shell_pkg::TGT_DNA];

    // ==============================
    // Read mux and write rules
    // ==============================
    always_comb begin
        rd_val = '0;
        wr_err = 1'b1;
        if (i_sel[shell_pkg::TGT_DNA]) begin
            // High word at index 0, DNA is read-only
            case (i_index)
                10'd0:   rd_val = i_dna[95:64];
                10'd1:   rd_val = i_dna[63:32];
                10'd2:   rd_val = i_dna[31:0];
                default: rd_val = '0;
            endcase
        end else begin
            case (i_index)
                shell_pkg::REG_BUILD:    rd_val = BUILD_TIMESTAMP;
                shell_pkg::REG_STATUS:   rd_val = {30'b0, !o_core_srst, i_dna_valid};
                shell_pkg::REG_SCRATCH: begin
                    rd_val = scratch;
                    wr_err = 1'b0;
                end
                shell_pkg::REG_RST_CTRL: wr_err = 1'b0;
                default:                 rd_val = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_done      <= 1'b0;
            scratch     <= '0;
            o_core_srst <= 1'b0;
            rst_cnt     <= '0;
        end else begin
            o_done <= cfg_hit || dna_hit;
            if (cfg_hit && i_wr && i_index == shell_pkg::REG_SCRATCH) begin
                scratch <= i_wdata;
            end
            // Pulse starts on the executing edge, lasts CORE_RST_CYCLES
            if (cfg_hit && i_wr && i_index == shell_pkg::REG_RST_CTRL && i_wdata[0]) begin
                o_core_srst <= 1'b1;
                rst_cnt     <= shell_pkg::RST_CNT_LOAD;
            end else if (o_core_srst) begin
                if (rst_cnt == '0) begin
                    o_core_srst <= 1'b0;
                end else begin
                    rst_cnt <= rst_cnt - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_hit || dna_hit) begin
            o_rdata <= i_wr ? '0 : rd_val;
            o_err   <= i_wr && wr_err;
        end
    end

endmodule : syscfg_reg_blk

//--- tests/tb_shell_top.sv
`timescale 1ns/10ps

module tb_shell_top;

    localparam logic [31:0] BUILD_ID        = 32'hb17d_0a3c;
    localparam int          CLK_PERIOD      = 8;
    localparam int          N_ACCESSES      = 40;
    localparam int          WATCHDOG_CYCLES = N_ACCESSES * 64 + 200;

    logic                 clk;
    logic                 i_rst;
    logic                 i_req;
    logic                 i_wr;
    shell_pkg::reg_addr_u i_addr;
    logic [31:0]          i_wdata;
    logic                 o_ack;
    logic [31:0]          o_rdata;
    logic                 o_err;
    logic                 o_app_req;
    logic                 o_app_wr;
    logic [14:0]          o_app_addr;
    logic [31:0]          o_app_wdata;
    logic                 i_app_ack;
    logic [31:0]          i_app_rdata;
    logic                 i_app_err;
    logic                 o_dna_read;
    logic                 o_dna_shift;
    logic                 i_dna_dout;
    logic                 o_core_srst;

    logic [31:0]          lfsr;
    logic [95:0]          dna_model;
    logic [95:0]          dna_sr;
    int                   dna_read_cnt;
    int                   dna_shift_cnt;
    logic [31:0]          app_rdata_tbl [8];
    logic                 app_err_tbl [8];
    shell_pkg::reg_addr_u seen_addr;
    logic                 seen_wr;
    logic [31:0]          seen_wdata;
    int                   app_req_count;
    int unsigned          app_dly;
    int                   srst_run;
    int                   srst_len;
    int                   last_lat;
    int                   n_checks;
    int                   n_errors;

    shell_top #(
        .BUILD_TIMESTAMP ( BUILD_ID )
    ) dut0 (
        .clk, .i_rst, .i_req, .i_wr, .i_addr, .i_wdata, .o_ack, .o_rdata, .o_err,
        .o_app_req, .o_app_wr, .o_app_addr, .o_app_wdata,
        .i_app_ack, .i_app_rdata, .i_app_err,
        .o_dna_read, .o_dna_shift, .i_dna_dout, .o_core_srst
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==============================
    // Random source and addresses
    // ==============================
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic shell_pkg::reg_addr_u plat_addr(input logic [2:0] blk,
                                                       input logic [9:0] idx,
                                                       input logic [1:0] boff);
        shell_pkg::reg_addr_u a;
        a.plat.top      = 1'b0;
        a.plat.blk      = blk;
        a.plat.index    = idx;
        a.plat.byte_off = boff;
        return a;
    endfunction

    function automatic shell_pkg::reg_addr_u app_addr(input logic [14:0] off);
        shell_pkg::reg_addr_u a;
        a.bus.app    = 1'b1;
        a.bus.offset = off;
        return a;
    endfunction

    // ==============================
    // DNA, core and reset models
    // ==============================
    always @(posedge clk) begin
        if (o_dna_read === 1'b1) begin
            dna_read_cnt <= dna_read_cnt + 1;
            dna_sr       <= dna_model;
            i_dna_dout   <= dna_model[95];
        end else if (o_dna_shift === 1'b1) begin
            dna_shift_cnt <= dna_shift_cnt + 1;
            dna_sr        <= {dna_sr[94:0], 1'b0};
            i_dna_dout    <= dna_sr[94];
        end
    end

    // Application core with a random answer delay
    always begin
        @(posedge clk);
        if (o_app_req === 1'b1 && i_app_ack === 1'b0) begin
            seen_addr = app_addr(o_app_addr);
            seen_wr = o_app_wr;
            seen_wdata = o_app_wdata;
            app_req_count++;
            app_dly = rand_bits(3);
            repeat (app_dly) @(posedge clk);
            i_app_ack   <= 1'b1;
            i_app_rdata <= app_rdata_tbl[o_app_addr[2:0]];
            i_app_err   <= app_err_tbl[o_app_addr[2:0]];
            do @(posedge clk); while (o_app_req === 1'b1);
            i_app_ack <= 1'b0;
        end
    end

    // Length of the last core reset pulse in cycles
    always @(posedge clk) begin
        if (o_core_srst === 1'b1) begin
            srst_run <= srst_run + 1;
        end else if (srst_run != 0) begin
            srst_len <= srst_run;
            srst_run <= 0;
        end
    end

    task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input shell_pkg::reg_addr_u got,
                              input shell_pkg::reg_addr_u exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // One four-phase access on the host bus
    task automatic host_access(input logic wr, input shell_pkg::reg_addr_u addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        int k;
        @(posedge clk);
        i_req   <= 1'b1;
        i_wr    <= wr;
        i_addr  <= addr;
        i_wdata <= wdata;
        k = 0;
        do begin
            @(posedge clk);
            k++;
        end while (o_ack !== 1'b1);
        rdata = o_rdata;
        err = o_err;
        // Req was seen on edge 1 and ack rose on the edge before this one
        last_lat = k - 2;
        i_req <= 1'b0;
        k = 0;
        do begin
            @(posedge clk);
            k++;
        end while (o_ack !== 1'b0);
        check_data("ack release delay", 32'(k - 1), 32'd1);
    endtask

    task automatic host_read(input shell_pkg::reg_addr_u addr, output logic [31:0] rdata,
                             output logic err);
        host_access(1'b0, addr, 32'h0, rdata, err);
    endtask

    task automatic host_write(input shell_pkg::reg_addr_u addr, input logic [31:0] wdata,
                              output logic err);
        logic [31:0] unused_rd;
        host_access(1'b1, addr, wdata, unused_rd, err);
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic test_reset_build();
        logic [31:0] rd;
        logic        er;
        check_flag("o_ack after reset", o_ack, 1'b0);
        check_flag("o_app_req after reset", o_app_req, 1'b0);
        check_flag("o_dna_shift after reset", o_dna_shift, 1'b0);
        check_flag("o_core_srst after reset", o_core_srst, 1'b0);
        host_read(plat_addr(shell_pkg::BLK_SYSCFG, shell_pkg::REG_BUILD, 2'b00), rd, er);
        check_data("build id", rd, BUILD_ID);
        check_flag("build read err", er, 1'b0);
        check_data("platform ack latency", 32'(last_lat), 32'd4);
    endtask

    task automatic test_scratch();
        logic [31:0] v;
        logic [31:0] rd;
        logic        er;
        repeat (4) begin
            v = rand_bits(32);
            host_write(plat_addr(shell_pkg::BLK_SYSCFG, shell_pkg::REG_SCRATCH, 2'b00), v, er);
            check_flag("scratch write err", er, 1'b0);
            host_read(plat_addr(shell_pkg::BLK_SYSCFG, shell_pkg::REG_SCRATCH, 2'b00), rd, er);
            check_data("scratch readback", rd, v);
            check_data("scratch ack latency", 32'(last_lat), 32'd4);
        end
        host_write(plat_addr(shell_pkg::BLK_SYSCFG, shell_pkg::REG_BUILD, 2'b00), ~BUILD_ID, er);
        check_flag("build write err", er, 1'b1);
        host_read(plat_addr(shell_pkg::BLK_SYSCFG, shell_pkg::REG_BUILD, 2'b00), rd, er);
        check_data("build id after write", rd, BUILD_ID);
    endtask

    task automatic test_dna();
        logic [31:0] rd;
        logic        er;
        do begin
            host_read(plat_addr(shell_pkg::BLK_SYSCFG, shell_pkg::REG_STATUS, 2'b00), rd, er);
        end while (rd[0] !== 1'b1);
        check_data("o_dna_read cycles", 32'(dna_read_cnt), 32'd1);
        check_data("o_dna_shift cycles", 32'(dna_shift_cnt), 32'd96);
        for (int i = 0; i < 3; i++) begin
            host_read(plat_addr(shell_pkg::BLK_DNA, 10'(i), 2'b00), rd, er);
            check_data("dna word", rd, dna_model[95 - 32 * i -: 32]);
            check_flag("dna read err", er, 1'b0);
            check_data("dna ack latency", 32'(last_lat), 32'd4);
        end
        host_write(plat_addr(shell_pkg::BLK_DNA, 10'd0, 2'b00), 32'h1234_5678, er);
        check_flag("dna write err", er, 1'b1);
    endtask

    task automatic test_app();
        logic [31:0] tmp;
        logic [14:0] off;
        logic        wr;
        logic [31:0] wd;
        logic [31:0] rd;
        logic        er;
        int          cnt0;
        repeat (8) begin
            tmp = rand_bits(15);
            off = tmp[14:0];
            tmp = rand_bits(1);
            wr = tmp[0];
            wd = rand_bits(32);
            cnt0 = app_req_count;
            host_access(wr, app_addr(off), wd, rd, er);
            check_data("app request count", 32'(app_req_count), 32'(cnt0 + 1));
            check_addr("o_app_addr", seen_addr, app_addr(off));
            check_flag("o_app_wr", seen_wr, wr);
            check_data("o_app_wdata", seen_wdata, wd);
            check_data("app rdata", rd, app_rdata_tbl[off[2:0]]);
            check_flag("app err", er, app_err_tbl[off[2:0]]);
        end
    endtask

    task automatic test_unmapped();
        logic [31:0] rd;
        logic        er;
        int          cnt0;
        cnt0 = app_req_count;
        for (int b = 1; b < 4; b++) begin
            host_read(plat_addr(shell_pkg::BLK_SYSCFG, shell_pkg::REG_SCRATCH, 2'(b)), rd, er);
            check_flag("byte offset err", er, 1'b1);
            check_data("byte offset rdata", rd, 32'h0);
        end
        // Sysmon, QSPI and the spare blocks
        for (int b = 2; b < 8; b++) begin
            host_read(plat_addr(3'(b), 10'd0, 2'b00), rd, er);
            check_flag("unmapped block err", er, 1'b1);
            check_data("unmapped block rdata", rd, 32'h0);
            check_data("unmapped ack latency", 32'(last_lat), 32'd4);
        end
        check_data("app requests on unmapped", 32'(app_req_count), 32'(cnt0));
    endtask

    task automatic test_core_reset();
        logic [31:0] rd;
        logic        er;
        host_write(plat_addr(shell_pkg::BLK_SYSCFG, shell_pkg::REG_RST_CTRL, 2'b00), 32'h1, er);
        check_flag("reset ctrl write err", er, 1'b0);
        host_read(plat_addr(shell_pkg::BLK_SYSCFG, shell_pkg::REG_STATUS, 2'b00), rd, er);
        check_flag("status reset done in pulse", rd[1], 1'b0);
        check_flag("status dna valid in pulse", rd[0], 1'b1);
        do @(posedge clk); while (o_core_srst === 1'b1);
        @(posedge clk);
        check_data("core reset pulse length", 32'(srst_len), 32'd16);
        host_read(plat_addr(shell_pkg::BLK_SYSCFG, shell_pkg::REG_STATUS, 2'b00), rd, er);
        check_flag("status reset done after pulse", rd[1], 1'b1);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        clk = 1'b0;
        i_rst = 1'b1;
        i_req = 1'b0;
        i_wr = 1'b0;
        i_addr = '0;
        i_wdata = '0;
        i_app_ack = 1'b0;
        i_app_rdata = '0;
        i_app_err = 1'b0;
        i_dna_dout = 1'b0;
        lfsr = 32'h6aaf08b7;
        dna_read_cnt = 0;
        dna_shift_cnt = 0;
        app_req_count = 0;
        srst_run = 0;
        srst_len = 0;
        n_checks = 0;
        n_errors = 0;
        dna_model[95:64] = rand_bits(32);
        dna_model[63:32] = rand_bits(32);
        dna_model[31:0] = rand_bits(32);
        for (int i = 0; i < 8; i++) begin
            app_rdata_tbl[i] = 32'h5a00_0000 + 32'(i) * 32'h0001_0203;
            app_err_tbl[i] = (i % 3 == 2);
        end
        repeat (4) @(posedge clk);
        i_rst <= 1'b0;
        @(posedge clk);
        test_reset_build();
        test_scratch();
        test_dna();
        test_app();
        test_unmapped();
        test_core_reset();
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_shell_top
